// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv32_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv --top-module tb_rv32_core \
  -f rv32_core.f --Mdir obj_dir -o tb_rv32_core

./obj_dir/tb_rv32_core | tee sim.log

if grep -qx "TEST OK" sim.log; then
  exit 0
else
  exit 1
fi

// ==== rv32_core.f ====
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/ex_stage.sv
verilog/rv32_core.sv
verification/tb_clock_gen.sv
verification/tb_rv32_core.sv

// ==== verification/program_cases.txt ====
// First word is the instruction count, then one line per instruction
// Columns: instruction word, expected rd (ff means no retire), expected rd value
00000018
00500093 01 00000005 // addi x1, x0, 5
ffd00113 02 fffffffd // addi x2, x0, -3
002081b3 03 00000002 // add x3, x1, x2
40208233 04 00000008 // sub x4, x1, x2
00112293 05 00000001 // slti x5, x2, 1
00113313 06 00000000 // sltiu x6, x2, 1
0f00c393 07 000000f5 // xori x7, x1, 0xf0
00409413 08 00000050 // slli x8, x1, 4
00415493 09 0fffffff // srli x9, x2, 4
40415513 0a ffffffff // srai x10, x2, 4
800005b7 0b 80000000 // lui x11, 0x80000
0015a633 0c 00000001 // slt x12, x11, x1
0015b6b3 0d 00000000 // sltu x13, x11, x1
4085d733 0e ffff8000 // sra x14, x11, x8
0085d7b3 0f 00008000 // srl x15, x11, x8
000000ff ff 00000000 // unknown opcode, rd field x1
00f0e833 10 00008005 // or x16, x1, x15
7ff08013 00 00000804 // addi x0, x1, 0x7ff
000008b3 11 00000000 // add x17, x0, x0
00787933 12 00000005 // and x18, x16, x7
fff90993 13 00000004 // addi x19, x18, -1
01399a33 14 00000040 // sll x20, x19, x19
013a4ab3 15 00000044 // xor x21, x20, x19
41500b33 16 ffffffbc // sub x22, x0, x21

// ==== verification/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
  output logic o_clk,
  output logic o_arst_n
);

  // 40 ns period
  localparam int unsigned HALF_PERIOD_NS = 20;
  // Reset held low over this many rising edges
  localparam int unsigned RESET_CYCLES   = 3;
  // Release lands just after an edge, away from sampling
  localparam int unsigned RELEASE_DELAY  = 2;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #(RELEASE_DELAY);
    o_arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/tb_rv32_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_rv32_core;

  // Case file holds a count, then three words per instruction
  localparam int unsigned MAX_CASES    = 64;
  localparam int unsigned CASE_WORDS   = 1 + 3 * MAX_CASES;
  // ADDI x0, x0, 0 fills fetches past the program
  localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
  // rd column value for an instruction that must not retire
  localparam logic [31:0] NO_RETIRE_RD = 32'h0000_00ff;
  // Inputs change this long after the rising edge
  localparam int unsigned DRIVE_DELAY  = 2;
  // Slack cycles on top of program length and latency
  localparam int unsigned WDOG_MARGIN  = 20;

  logic                           clk;
  logic                           arst_n;
  logic [isa_pkg::INSTR_W-1:0]    instr;
  logic [isa_pkg::XLEN-1:0]       pc;
  logic                           vld;
  logic [isa_pkg::XLEN-1:0]       retire_pc;
  logic [isa_pkg::REG_ADDR_W-1:0] retire_rd;
  logic [isa_pkg::XLEN-1:0]       retire_data;

  // Raw words from the case file
  logic [31:0] case_words [0:CASE_WORDS-1];
  int unsigned num_cases;
  // Program instructions expected on the retire port
  int unsigned prog_retires;
  bit          cases_loaded;
  int unsigned err_cnt;
  int unsigned check_cnt;

  // Expected retire records, oldest at the front
  logic [31:0] exp_pc_q    [$];
  logic [31:0] exp_rd_q    [$];
  logic [31:0] exp_data_q  [$];
  int unsigned exp_cycle_q [$];

  tb_clock_gen clock_gen_i (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  rv32_core dut_i (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_instr       (instr),
    .o_pc          (pc),
    .o_vld         (vld),
    .o_retire_pc   (retire_pc),
    .o_retire_rd   (retire_rd),
    .o_retire_data (retire_data)
  );

  // Compare one value, log a mismatch in hex
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  // Read the program and its expected results
  task automatic load_cases();
    $readmemh("verification/program_cases.txt", case_words);
    num_cases = case_words[0];
    if ($isunknown(case_words[0]) || num_cases == 0 || num_cases > MAX_CASES) begin
      $display("case file is missing or gives a bad instruction count");
      err_cnt++;
      num_cases = 0;
    end
    for (int i = 0; i < int'(num_cases); i++) begin
      if (case_words[2 + 3 * i] != NO_RETIRE_RD) begin
        prog_retires++;
      end
    end
    cases_loaded = 1'b1;
  endtask

  // Instruction memory contents by word index
  function automatic logic [31:0] fetch_word(input int unsigned idx);
    if (idx < num_cases) begin
      return case_words[1 + 3 * idx];
    end
    return NOP_WORD;
  endfunction

  // Queue the retire record of a fetched instruction, if it retires
  task automatic push_expected(input int unsigned idx, input logic [31:0] fetch_pc,
                               input int unsigned retire_cycle);
    logic [31:0] rd_word;
    logic [31:0] data_word;
    // Past the program, NOPs retire to x0 with zero
    rd_word   = '0;
    data_word = '0;
    if (idx < num_cases) begin
      rd_word   = case_words[2 + 3 * idx];
      data_word = case_words[3 + 3 * idx];
    end
    if (rd_word != NO_RETIRE_RD) begin
      exp_pc_q.push_back(fetch_pc);
      exp_rd_q.push_back(rd_word);
      exp_data_q.push_back(data_word);
      exp_cycle_q.push_back(retire_cycle);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
  endtask

  // Cycle loop, cycle 0 is the first one after reset release
  initial begin
    int unsigned cycle;
    int unsigned retired;
    int unsigned mem_idx;
    int unsigned exp_idx;
    logic [31:0] fetch_pc;
    logic [31:0] head_pc;
    logic [31:0] head_rd;
    logic [31:0] head_data;
    int unsigned head_cycle;
    bit          done;

    instr        = NOP_WORD;
    err_cnt      = 0;
    check_cnt    = 0;
    prog_retires = 0;
    load_cases();
    cycle    = 0;
    retired  = 0;
    fetch_pc = core_pkg::RESET_PC;
    done     = (prog_retires == 0);

    @(posedge arst_n);
    while (!done) begin
      // Mid-cycle, DUT outputs are settled
      @(negedge clk);
      // PC starts at reset value and only steps
      check_value("o_pc", pc, fetch_pc);
      mem_idx = pc >> 2;
      exp_idx = fetch_pc >> 2;
      if (vld) begin
        if (exp_pc_q.size() == 0) begin
          $display("retire in cycle %0d with no instruction expected", cycle);
          err_cnt++;
        end else begin
          head_pc    = exp_pc_q.pop_front();
          head_rd    = exp_rd_q.pop_front();
          head_data  = exp_data_q.pop_front();
          head_cycle = exp_cycle_q.pop_front();
          // Early, late or extra retires show up as a cycle mismatch
          check_value("retire cycle", cycle, head_cycle);
          check_value("o_retire_pc", retire_pc, head_pc);
          check_value("o_retire_rd", 32'(retire_rd), head_rd);
          check_value("o_retire_data", retire_data, head_data);
          if (head_pc < num_cases * 4) begin
            retired++;
          end
        end
        done = (retired == prog_retires);
      end
      // Memory answers one cycle after the PC
      @(posedge clk);
      #(DRIVE_DELAY);
      instr = fetch_word(mem_idx);
      push_expected(exp_idx, fetch_pc, cycle + core_pkg::RETIRE_LATENCY);
      fetch_pc = fetch_pc + core_pkg::PC_STEP;
      cycle++;
    end

    report_counts();
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bounds the run by program length plus pipeline depth
  initial begin
    int unsigned limit;
    wait (cases_loaded);
    limit = num_cases + core_pkg::RETIRE_LATENCY + WDOG_MARGIN;
    @(posedge arst_n);
    repeat (limit) @(posedge clk);
    $display("watchdog expired before all instructions retired");
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // Address of the first fetch after reset
  localparam logic [isa_pkg::XLEN-1:0] RESET_PC = '0;

  // No branches, so the PC only moves by one word per cycle
  localparam logic [isa_pkg::XLEN-1:0] PC_STEP = 4;

  // Cycles from a PC on o_pc to its retire on o_vld
  // IF presents, memory returns, ID captures
  // EX register loads, then WB register loads
  localparam int unsigned RETIRE_LATENCY = 4;

endpackage

`default_nettype wire

// ==== verilog/ex_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module ex_stage (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_vld,
  input  isa_pkg::alu_op_e               i_alu_op,
  input  logic [isa_pkg::XLEN-1:0]       i_op_a,
  input  logic [isa_pkg::XLEN-1:0]       i_op_b,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_rd,
  input  logic [isa_pkg::XLEN-1:0]       i_pc,
  output logic                           o_fwd_vld,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_fwd_rd,
  output logic [isa_pkg::XLEN-1:0]       o_fwd_data,
  output logic                           o_wb_vld,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_wb_rd,
  output logic [isa_pkg::XLEN-1:0]       o_wb_data,
  output logic [isa_pkg::XLEN-1:0]       o_wb_pc
);

  logic [isa_pkg::SHAMT_W-1:0]    shamt;
  logic [isa_pkg::XLEN-1:0]       alu_res;
  // EX-to-WB register
  logic                           wb_vld_q;
  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd_q;
  logic [isa_pkg::XLEN-1:0]       wb_data_q;
  logic [isa_pkg::XLEN-1:0]       wb_pc_q;

  // Only the low bits of B count as a shift amount
  assign shamt = i_op_b[isa_pkg::SHAMT_W-1:0];

  always_comb begin
    case (i_alu_op)
      isa_pkg::ALU_ADD:    alu_res = i_op_a + i_op_b;
      isa_pkg::ALU_SUB:    alu_res = i_op_a - i_op_b;
      isa_pkg::ALU_SLL:    alu_res = i_op_a << shamt;
      // Compares return 0 or 1
      isa_pkg::ALU_SLT:    alu_res = {{(isa_pkg::XLEN-1){1'b0}},
                                      $signed(i_op_a) < $signed(i_op_b)};
      isa_pkg::ALU_SLTU:   alu_res = {{(isa_pkg::XLEN-1){1'b0}}, i_op_a < i_op_b};
      isa_pkg::ALU_XOR:    alu_res = i_op_a ^ i_op_b;
      isa_pkg::ALU_SRL:    alu_res = i_op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(i_op_a) >>> shamt);
      isa_pkg::ALU_OR:     alu_res = i_op_a | i_op_b;
      isa_pkg::ALU_AND:    alu_res = i_op_a & i_op_b;
      isa_pkg::ALU_PASS_B: alu_res = i_op_b;
      default:             alu_res = '0;
    endcase
  end

  // Result goes back to decode in the same cycle
  assign o_fwd_vld  = i_vld;
  assign o_fwd_rd   = i_rd;
  assign o_fwd_data = alu_res;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wb_vld_q <= 1'b0;
    end else begin
      wb_vld_q <= i_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_rd_q   <= i_rd;
    wb_data_q <= alu_res;
    wb_pc_q   <= i_pc;
  end

  // Drives regfile write, retire port and the older forward path
  assign o_wb_vld  = wb_vld_q;
  assign o_wb_rd   = wb_rd_q;
  assign o_wb_data = wb_data_q;
  assign o_wb_pc   = wb_pc_q;

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module id_stage (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic [isa_pkg::INSTR_W-1:0]    i_instr,
  input  logic                           i_fetch_vld,
  input  logic [isa_pkg::XLEN-1:0]       i_fetch_pc,
  input  logic [isa_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [isa_pkg::XLEN-1:0]       i_rs2_data,
  input  logic                           i_ex_fwd_vld,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_ex_fwd_rd,
  input  logic [isa_pkg::XLEN-1:0]       i_ex_fwd_data,
  input  logic                           i_wb_vld,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_wb_rd,
  input  logic [isa_pkg::XLEN-1:0]       i_wb_data,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_rs1_addr,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_rs2_addr,
  output logic                           o_ex_vld,
  output isa_pkg::alu_op_e               o_ex_alu_op,
  output logic [isa_pkg::XLEN-1:0]       o_ex_op_a,
  output logic [isa_pkg::XLEN-1:0]       o_ex_op_b,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_ex_rd,
  output logic [isa_pkg::XLEN-1:0]       o_ex_pc
);

  // Pick the youngest producer of a source register
  // Index zero always reads as zero
  function automatic logic [isa_pkg::XLEN-1:0] fwd_operand(
    input logic [isa_pkg::REG_ADDR_W-1:0] src,
    input logic [isa_pkg::XLEN-1:0]       rf_data,
    input logic                           ex_vld,
    input logic [isa_pkg::REG_ADDR_W-1:0] ex_rd,
    input logic [isa_pkg::XLEN-1:0]       ex_data,
    input logic                           wb_vld,
    input logic [isa_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic [isa_pkg::XLEN-1:0]       wb_data
  );
    if (src == '0) return '0;
    // Previous instruction, still in the ALU
    if (ex_vld && (ex_rd == src)) return ex_data;
    // Two back, being written this very cycle
    if (wb_vld && (wb_rd == src)) return wb_data;
    return rf_data;
  endfunction

  // Address of the fetch in flight, follows memory latency
  logic [isa_pkg::XLEN-1:0]       fetch_pc_q;
  // Captured instruction and its PC
  logic                           id_vld_q;
  logic [isa_pkg::INSTR_W-1:0]    id_instr_q;
  logic [isa_pkg::XLEN-1:0]       id_pc_q;
  // Decoded fields
  isa_pkg::opcode_e               opcode;
  isa_pkg::funct3_e               funct3;
  logic                           funct7_alt;
  logic [isa_pkg::REG_ADDR_W-1:0] rd;
  logic [isa_pkg::XLEN-1:0]       imm_i;
  logic [isa_pkg::XLEN-1:0]       imm_u;
  isa_pkg::alu_op_e               alu_op;
  logic                           known_op;
  logic [isa_pkg::XLEN-1:0]       rs1_val;
  logic [isa_pkg::XLEN-1:0]       rs2_val;
  logic [isa_pkg::XLEN-1:0]       op_b;
  // ID-to-EX register
  logic                           ex_vld_q;
  isa_pkg::alu_op_e               ex_alu_op_q;
  logic [isa_pkg::XLEN-1:0]       ex_op_a_q;
  logic [isa_pkg::XLEN-1:0]       ex_op_b_q;
  logic [isa_pkg::REG_ADDR_W-1:0] ex_rd_q;
  logic [isa_pkg::XLEN-1:0]       ex_pc_q;

  always_ff @(posedge i_clk) begin
    fetch_pc_q <= i_fetch_pc;
    if (i_fetch_vld) begin
      id_instr_q <= i_instr;
      id_pc_q    <= fetch_pc_q;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      id_vld_q <= 1'b0;
    end else begin
      id_vld_q <= i_fetch_vld;
    end
  end

  // Field extraction
  assign opcode     = isa_pkg::opcode_e'(id_instr_q[isa_pkg::OPCODE_LSB +: 7]);
  assign funct3     = isa_pkg::funct3_e'(id_instr_q[isa_pkg::FUNCT3_LSB +: 3]);
  assign funct7_alt = id_instr_q[isa_pkg::FUNCT7_ALT];
  assign rd         = id_instr_q[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
  assign o_rs1_addr = id_instr_q[isa_pkg::RS1_LSB +: isa_pkg::REG_ADDR_W];
  assign o_rs2_addr = id_instr_q[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W];

  // I-type sign extended from bit 31, U-type fills the low 12 bits with zero
  assign imm_i = {{(isa_pkg::XLEN-12){id_instr_q[isa_pkg::INSTR_W-1]}},
                  id_instr_q[isa_pkg::INSTR_W-1:isa_pkg::RS2_LSB]};
  assign imm_u = {id_instr_q[isa_pkg::INSTR_W-1:isa_pkg::FUNCT3_LSB],
                  {isa_pkg::FUNCT3_LSB{1'b0}}};

  // funct3 to ALU op
  always_comb begin
    case (funct3)
      // SUB only exists in OP, ADDI ignores bit 30
      isa_pkg::F3_ADD_SUB: alu_op = (opcode == isa_pkg::OP_REG && funct7_alt) ?
                                    isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     alu_op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     alu_op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU:    alu_op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:     alu_op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: alu_op = funct7_alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:      alu_op = isa_pkg::ALU_OR;
      default:             alu_op = isa_pkg::ALU_AND;
    endcase
    // LUI carries no funct3
    if (opcode == isa_pkg::OP_LUI) alu_op = isa_pkg::ALU_PASS_B;
  end

  // Operands, forwarded ahead of the regfile
  assign rs1_val = fwd_operand(o_rs1_addr, i_rs1_data, i_ex_fwd_vld, i_ex_fwd_rd,
                               i_ex_fwd_data, i_wb_vld, i_wb_rd, i_wb_data);
  assign rs2_val = fwd_operand(o_rs2_addr, i_rs2_data, i_ex_fwd_vld, i_ex_fwd_rd,
                               i_ex_fwd_data, i_wb_vld, i_wb_rd, i_wb_data);

  // Operand B source and opcode check
  always_comb begin
    case (opcode)
      isa_pkg::OP_REG: begin
        known_op = 1'b1;
        op_b     = rs2_val;
      end
      isa_pkg::OP_IMM: begin
        known_op = 1'b1;
        op_b     = imm_i;
      end
      isa_pkg::OP_LUI: begin
        known_op = 1'b1;
        op_b     = imm_u;
      end
      default: begin
        // Anything else becomes a bubble
        known_op = 1'b0;
        op_b     = imm_i;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ex_vld_q <= 1'b0;
    end else begin
      ex_vld_q <= id_vld_q && known_op;
    end
  end

  // Payload loads every cycle, valid qualifies it
  always_ff @(posedge i_clk) begin
    ex_alu_op_q <= alu_op;
    ex_op_a_q   <= rs1_val;
    ex_op_b_q   <= op_b;
    ex_rd_q     <= rd;
    ex_pc_q     <= id_pc_q;
  end

  assign o_ex_vld    = ex_vld_q;
  assign o_ex_alu_op = ex_alu_op_q;
  assign o_ex_op_a   = ex_op_a_q;
  assign o_ex_op_b   = ex_op_b_q;
  assign o_ex_rd     = ex_rd_q;
  assign o_ex_pc     = ex_pc_q;

endmodule

`default_nettype wire

// ==== verilog/if_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module if_stage (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  output logic [isa_pkg::XLEN-1:0] o_pc,
  output logic                     o_fetch_vld
);

  // Address currently presented to instruction memory
  logic [isa_pkg::XLEN-1:0] pc_q;
  // High once a fetch has been in flight for one cycle
  logic                     fetch_vld_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q        <= core_pkg::RESET_PC;
      fetch_vld_q <= 1'b0;
    end else begin
      // Straight-line fetch, one word per cycle
      pc_q        <= pc_q + core_pkg::PC_STEP;
      // First cycle after reset has no returned word yet
      fetch_vld_q <= 1'b1;
    end
  end

  assign o_pc        = pc_q;
  assign o_fetch_vld = fetch_vld_q;

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Datapath and register file geometry
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned INSTR_W    = 32;
  // Shift amount is taken from the low bits of operand B
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  // Instruction field positions
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_LSB = 25;
  // Bit 30, picks SUB over ADD and SRA over SRL
  localparam int unsigned FUNCT7_ALT = FUNCT7_LSB + 5;

  // Major opcodes kept in this core
  typedef enum logic [6:0] {
    OP_REG = 7'b0110011,
    OP_IMM = 7'b0010011,
    OP_LUI = 7'b0110111
  } opcode_e;

  // Integer funct3 encodings, shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    // LUI, result is operand B unchanged
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none
`timescale 1ns/1ns

module regfile (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_wr_en,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [isa_pkg::XLEN-1:0]       i_wr_data,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_rd_addr_a,
  input  logic [isa_pkg::REG_ADDR_W-1:0] i_rd_addr_b,
  output logic [isa_pkg::XLEN-1:0]       o_rd_data_a,
  output logic [isa_pkg::XLEN-1:0]       o_rd_data_b
);

  // Integer registers x1 to x31
  // x0 has no storage and always reads as zero
  logic [isa_pkg::XLEN-1:0] regs_q [1:isa_pkg::NUM_REGS-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_wr_en && (i_wr_addr != '0)) begin
      // Writes to x0 are dropped
      regs_q[i_wr_addr] <= i_wr_data;
    end
  end

  // Asynchronous reads
  // Same-index write in this cycle is not visible until the next one
  assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs_q[i_rd_addr_a];
  assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs_q[i_rd_addr_b];

endmodule

`default_nettype wire

// ==== verilog/rv32_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module rv32_core (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic [isa_pkg::INSTR_W-1:0]    i_instr,
  output logic [isa_pkg::XLEN-1:0]       o_pc,
  output logic                           o_vld,
  output logic [isa_pkg::XLEN-1:0]       o_retire_pc,
  output logic [isa_pkg::REG_ADDR_W-1:0] o_retire_rd,
  output logic [isa_pkg::XLEN-1:0]       o_retire_data
);

  // IF to ID
  logic                           fetch_vld;
  // ID to and from regfile
  logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [isa_pkg::XLEN-1:0]       rs1_data;
  logic [isa_pkg::XLEN-1:0]       rs2_data;
  // ID to EX
  logic                           ex_vld;
  isa_pkg::alu_op_e               ex_alu_op;
  logic [isa_pkg::XLEN-1:0]       ex_op_a;
  logic [isa_pkg::XLEN-1:0]       ex_op_b;
  logic [isa_pkg::REG_ADDR_W-1:0] ex_rd;
  logic [isa_pkg::XLEN-1:0]       ex_pc;
  // EX forward back to ID
  logic                           fwd_vld;
  logic [isa_pkg::REG_ADDR_W-1:0] fwd_rd;
  logic [isa_pkg::XLEN-1:0]       fwd_data;
  // WB bundle
  logic                           wb_vld;
  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [isa_pkg::XLEN-1:0]       wb_data;
  logic [isa_pkg::XLEN-1:0]       wb_pc;

  if_stage if_stage_inst (
    .i_clk, .i_arst_n,
    .o_pc, .o_fetch_vld(fetch_vld)
  );

  // o_pc doubles as the fetch address seen by decode
  id_stage id_stage_inst (
    .i_clk, .i_arst_n, .i_instr,
    .i_fetch_vld(fetch_vld), .i_fetch_pc(o_pc),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_ex_fwd_vld(fwd_vld), .i_ex_fwd_rd(fwd_rd), .i_ex_fwd_data(fwd_data),
    .i_wb_vld(wb_vld), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
    .o_ex_vld(ex_vld), .o_ex_alu_op(ex_alu_op), .o_ex_op_a(ex_op_a),
    .o_ex_op_b(ex_op_b), .o_ex_rd(ex_rd), .o_ex_pc(ex_pc)
  );

  // Written from WB, read from ID
  regfile regfile_inst (
    .i_clk, .i_arst_n,
    .i_wr_en(wb_vld), .i_wr_addr(wb_rd), .i_wr_data(wb_data),
    .i_rd_addr_a(rs1_addr), .i_rd_addr_b(rs2_addr),
    .o_rd_data_a(rs1_data), .o_rd_data_b(rs2_data)
  );

  ex_stage ex_stage_inst (
    .i_clk, .i_arst_n,
    .i_vld(ex_vld), .i_alu_op(ex_alu_op), .i_op_a(ex_op_a), .i_op_b(ex_op_b),
    .i_rd(ex_rd), .i_pc(ex_pc),
    .o_fwd_vld(fwd_vld), .o_fwd_rd(fwd_rd), .o_fwd_data(fwd_data),
    .o_wb_vld(wb_vld), .o_wb_rd(wb_rd), .o_wb_data(wb_data), .o_wb_pc(wb_pc)
  );

  // Retire port mirrors the WB register
  assign o_vld         = wb_vld;
  assign o_retire_pc   = wb_pc;
  assign o_retire_rd   = wb_rd;
  assign o_retire_data = wb_data;

endmodule

`default_nettype wire
